// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module lsu_tb -f flist.f

sim:
	verilator --binary --timing --assert --top-module lsu_tb -f flist.f -o lsu_sim
	./obj_dir/lsu_sim | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== flist.f ====
+incdir+source
source/lsu_pkg.sv
source/lsu_interfaces.sv
source/data_memory.sv
source/mem_arbiter.sv
source/store_queue.sv
source/load_buffer.sv
source/lsu_top.sv
tests/lsu_tb.sv

// ==== source/data_memory.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module data_memory (
    input  logic            clock,
    mem_port_if.memory      port
);
    logic [`DATA_WIDTH-1:0] words [2**`ADDR_WIDTH];

    // Each word starts out holding its own address
    initial begin
        for (int a = 0; a < 2**`ADDR_WIDTH; a++) begin
            words[a] = a[`DATA_WIDTH-1:0];
        end
    end

    assign port.grant = 1'b1;

    always @(posedge clock) begin
        if (port.req && port.mreq.write) begin
            words[port.mreq.addr] <= port.mreq.wdata;
        end
    end

    always_ff @(posedge clock) begin
        port.rvalid <= port.req && !port.mreq.write;
        port.rdata <= words[port.mreq.addr];
        port.ridx <= port.mreq.ld_idx;
    end

endmodule

// ==== source/load_buffer.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module load_buffer (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        alloc,
    output logic [`LB_IDX_WIDTH-1:0]    alloc_idx,
    output logic                        full,
    input  logic                        resolve_valid,
    input  logic [`LB_IDX_WIDTH-1:0]    resolve_idx,
    input  logic [`ADDR_WIDTH-1:0]      resolve_addr,
    input  logic [`TAG_WIDTH-1:0]       resolve_tag,
    output logic                        done_valid,
    output logic [`TAG_WIDTH-1:0]       done_tag,
    output logic [`DATA_WIDTH-1:0]      done_data,
    mem_port_if.requester               mem,
    store_view_if.viewer                stores
);
    lsu_pkg::lb_entry_t entries [`LB_DEPTH];

    logic [`LB_DEPTH-1:0]        ready;
    logic [`LB_IDX_WIDTH-1:0]    issue_idx;
    logic                        stale_older;

    // Lowest free slot
    always_comb begin
        alloc_idx = '0;
        full = 1'b1;
        for (int i = `LB_DEPTH - 1; i >= 0; i--) begin
            if (!entries[i].busy) begin
                alloc_idx = i[`LB_IDX_WIDTH-1:0];
                full = 1'b0;
            end
        end
    end

    // An older store blocks while unresolved or on the same word
    always_comb begin
        for (int i = 0; i < `LB_DEPTH; i++) begin
            ready[i] = entries[i].busy && entries[i].resolved && !entries[i].issued;
            for (int s = 0; s < `SQ_DEPTH; s++) begin
                if (entries[i].older_stores[s] &&
                    (!stores.resolved[s] || stores.addr[s] == entries[i].addr)) begin
                    ready[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        issue_idx = '0;
        for (int i = `LB_DEPTH - 1; i >= 0; i--) begin
            if (ready[i]) begin
                issue_idx = i[`LB_IDX_WIDTH-1:0];
            end
        end
    end

    assign mem.req = |ready;
    assign mem.mreq = '{write: 1'b0, addr: entries[issue_idx].addr, wdata: '0,
                        ld_idx: issue_idx};

    // Response arrives one cycle after the grant
    assign done_valid = mem.rvalid;
    assign done_tag = entries[mem.ridx].tag;
    assign done_data = mem.rdata;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `LB_DEPTH; i++) begin
                entries[i].busy <= 1'b0;
                entries[i].resolved <= 1'b0;
                entries[i].issued <= 1'b0;
                entries[i].older_stores <= '0;
            end
        end else begin
            for (int i = 0; i < `LB_DEPTH; i++) begin
                if (stores.drain) begin
                    entries[i].older_stores[stores.drain_idx] <= 1'b0;
                end
            end
            if (alloc) begin
                entries[alloc_idx].busy <= 1'b1;
                entries[alloc_idx].resolved <= 1'b0;
                entries[alloc_idx].issued <= 1'b0;
                entries[alloc_idx].older_stores <= stores.valid;
            end
            if (resolve_valid) begin
                entries[resolve_idx].resolved <= 1'b1;
                entries[resolve_idx].addr <= resolve_addr;
                entries[resolve_idx].tag <= resolve_tag;
            end
            if (mem.req && mem.grant) begin
                entries[issue_idx].issued <= 1'b1;
            end
            if (mem.rvalid) begin
                entries[mem.ridx].busy <= 1'b0;
            end
        end
    end

    always_comb begin
        stale_older = 1'b0;
        for (int i = 0; i < `LB_DEPTH; i++) begin
            if (entries[i].busy && entries[i].older_stores[stores.alloc_idx]) begin
                stale_older = 1'b1;
            end
        end
    end

    a_resolve_busy: assert property (@(posedge clock) disable iff (reset)
        resolve_valid |-> entries[resolve_idx].busy);

    a_alloc_not_full: assert property (@(posedge clock) disable iff (reset)
        alloc |-> !full);

    // A free store slot must not still hold back any waiting load
    a_no_stale_older: assert property (@(posedge clock) disable iff (reset)
        !stores.valid[stores.alloc_idx] &&
        !(stores.drain && stores.drain_idx == stores.alloc_idx) |-> !stale_older);

endmodule

// ==== source/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Load buffer and store queue sizes
`define LB_DEPTH 4
`define SQ_DEPTH 4
`define LB_IDX_WIDTH 2
`define SQ_IDX_WIDTH 2

// Word addressed data memory
`define ADDR_WIDTH 6
`define DATA_WIDTH 16

// Destination register tag of a load
`define TAG_WIDTH 5

`endif

// ==== source/lsu_interfaces.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

// Request is taken when req and grant are both high
interface mem_port_if;
    logic                      req;
    lsu_pkg::mem_req_t         mreq;
    logic                      grant;
    logic                      rvalid;
    logic [`DATA_WIDTH-1:0]    rdata;
    logic [`LB_IDX_WIDTH-1:0]  ridx;

    modport requester (
        output req, mreq,
        input  grant, rvalid, rdata, ridx
    );

    modport arbiter (
        input  req, mreq,
        output grant, rvalid, rdata, ridx
    );

    modport memory (
        input  req, mreq,
        output grant, rvalid, rdata, ridx
    );
endinterface

// Store queue state as seen by the load buffer
interface store_view_if;
    logic [`SQ_DEPTH-1:0]                     valid;
    logic [`SQ_DEPTH-1:0]                     resolved;
    logic [`SQ_DEPTH-1:0][`ADDR_WIDTH-1:0]    addr;
    logic [`SQ_IDX_WIDTH-1:0]                 alloc_idx;
    logic                                     drain;
    logic [`SQ_IDX_WIDTH-1:0]                 drain_idx;

    modport source (output valid, resolved, addr, alloc_idx, drain, drain_idx);
    modport viewer (input valid, resolved, addr, alloc_idx, drain, drain_idx);
endinterface

// ==== source/lsu_pkg.sv ====
`include "lsu_config.svh"

package lsu_pkg;

    // One load buffer slot
    typedef struct packed {
        logic                      busy;
        logic                      resolved;
        logic [`ADDR_WIDTH-1:0]    addr;
        logic [`TAG_WIDTH-1:0]     tag;
        // Store slots that are older than this load
        logic [`SQ_DEPTH-1:0]      older_stores;
        logic                      issued;
    } lb_entry_t;

    // One store queue slot
    typedef struct packed {
        logic                      busy;
        logic                      resolved;
        logic                      committed;
        logic [`ADDR_WIDTH-1:0]    addr;
        logic [`DATA_WIDTH-1:0]    data;
    } sq_entry_t;

    // Request to the data memory
    typedef struct packed {
        logic                      write;
        logic [`ADDR_WIDTH-1:0]    addr;
        logic [`DATA_WIDTH-1:0]    wdata;
        // Load slot that gets the read response
        logic [`LB_IDX_WIDTH-1:0]  ld_idx;
    } mem_req_t;

endpackage

// ==== source/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_top (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        load_alloc,
    output logic [`LB_IDX_WIDTH-1:0]    load_alloc_idx,
    output logic                        load_full,
    input  logic                        load_resolve_valid,
    input  logic [`LB_IDX_WIDTH-1:0]    load_resolve_idx,
    input  logic [`ADDR_WIDTH-1:0]      load_resolve_addr,
    input  logic [`TAG_WIDTH-1:0]       load_resolve_tag,
    input  logic                        store_alloc,
    output logic [`SQ_IDX_WIDTH-1:0]    store_alloc_idx,
    output logic                        store_full,
    input  logic                        store_resolve_valid,
    input  logic [`SQ_IDX_WIDTH-1:0]    store_resolve_idx,
    input  logic [`ADDR_WIDTH-1:0]      store_resolve_addr,
    input  logic [`DATA_WIDTH-1:0]      store_resolve_data,
    input  logic                        store_commit,
    output logic                        load_done_valid,
    output logic [`TAG_WIDTH-1:0]       load_done_tag,
    output logic [`DATA_WIDTH-1:0]      load_done_data
);
    mem_port_if   ld_port ();
    mem_port_if   st_port ();
    mem_port_if   mem_port ();
    store_view_if store_view ();

    load_buffer u_load_buffer (
        .clock         (clock),
        .reset         (reset),
        .alloc         (load_alloc),
        .alloc_idx     (load_alloc_idx),
        .full          (load_full),
        .resolve_valid (load_resolve_valid),
        .resolve_idx   (load_resolve_idx),
        .resolve_addr  (load_resolve_addr),
        .resolve_tag   (load_resolve_tag),
        .done_valid    (load_done_valid),
        .done_tag      (load_done_tag),
        .done_data     (load_done_data),
        .mem           (ld_port.requester),
        .stores        (store_view.viewer)
    );

    store_queue u_store_queue (
        .clock         (clock),
        .reset         (reset),
        .alloc         (store_alloc),
        .alloc_idx     (store_alloc_idx),
        .full          (store_full),
        .resolve_valid (store_resolve_valid),
        .resolve_idx   (store_resolve_idx),
        .resolve_addr  (store_resolve_addr),
        .resolve_data  (store_resolve_data),
        .commit        (store_commit),
        .mem           (st_port.requester),
        .view          (store_view.source)
    );

    mem_arbiter u_mem_arbiter (
        .clock (clock),
        .reset (reset),
        .ld    (ld_port.arbiter),
        .st    (st_port.arbiter),
        .mem   (mem_port.requester)
    );

    data_memory u_data_memory (
        .clock (clock),
        .port  (mem_port.memory)
    );

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module mem_arbiter (
    input  logic            clock,
    input  logic            reset,
    mem_port_if.arbiter     ld,
    mem_port_if.arbiter     st,
    mem_port_if.requester   mem
);
    // Set when the store port lost the last conflict
    logic st_first;
    logic st_wins;

    assign st_wins = st.req && (!ld.req || st_first);

    assign ld.grant = mem.grant && ld.req && !st_wins;
    assign st.grant = mem.grant && st_wins;

    assign mem.req = ld.req || st.req;
    assign mem.mreq = st_wins ? st.mreq : ld.mreq;

    // Read data only ever belongs to a load
    assign ld.rvalid = mem.rvalid;
    assign ld.rdata = mem.rdata;
    assign ld.ridx = mem.ridx;
    assign st.rvalid = 1'b0;
    assign st.rdata = '0;
    assign st.ridx = '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            st_first <= 1'b0;
        end else if (ld.req && st.req && mem.grant) begin
            st_first <= !st_wins;
        end
    end

    // Back to back conflicts alternate between the ports
    a_last_loser_wins: assert property (@(posedge clock) disable iff (reset)
        $past(ld.req && st.req && mem.grant) && ld.req && st.req && mem.grant
        |-> st.grant == $past(ld.grant));

endmodule

// ==== source/store_queue.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module store_queue (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        alloc,
    output logic [`SQ_IDX_WIDTH-1:0]    alloc_idx,
    output logic                        full,
    input  logic                        resolve_valid,
    input  logic [`SQ_IDX_WIDTH-1:0]    resolve_idx,
    input  logic [`ADDR_WIDTH-1:0]      resolve_addr,
    input  logic [`DATA_WIDTH-1:0]      resolve_data,
    input  logic                        commit,
    mem_port_if.requester               mem,
    store_view_if.source                view
);
    lsu_pkg::sq_entry_t entries [`SQ_DEPTH];

    logic [`SQ_IDX_WIDTH-1:0]    head;
    logic [`SQ_IDX_WIDTH-1:0]    tail;
    logic [`SQ_IDX_WIDTH-1:0]    commit_ptr;
    logic [`SQ_IDX_WIDTH:0]      count;
    logic                        drain;

    assign full = (count == `SQ_DEPTH);
    assign alloc_idx = tail;

    // Only the committed head store goes to memory
    assign mem.req = entries[head].busy && entries[head].committed;
    assign mem.mreq = '{write: 1'b1, addr: entries[head].addr, wdata: entries[head].data,
                        ld_idx: '0};
    assign drain = mem.req && mem.grant;

    // Same cycle alloc counts as older, same cycle drain does not
    always_comb begin
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            view.valid[i] = entries[i].busy;
            view.resolved[i] = entries[i].busy && entries[i].resolved;
            view.addr[i] = entries[i].addr;
        end
        if (drain) begin
            view.valid[head] = 1'b0;
        end
        if (alloc) begin
            view.valid[tail] = 1'b1;
        end
    end

    assign view.alloc_idx = tail;
    assign view.drain = drain;
    assign view.drain_idx = head;

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            commit_ptr <= '0;
            count <= '0;
            for (int i = 0; i < `SQ_DEPTH; i++) begin
                entries[i].busy <= 1'b0;
                entries[i].resolved <= 1'b0;
                entries[i].committed <= 1'b0;
            end
        end else begin
            if (alloc) begin
                entries[tail].busy <= 1'b1;
                entries[tail].resolved <= 1'b0;
                entries[tail].committed <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (resolve_valid) begin
                entries[resolve_idx].resolved <= 1'b1;
                entries[resolve_idx].addr <= resolve_addr;
                entries[resolve_idx].data <= resolve_data;
            end
            if (commit) begin
                entries[commit_ptr].committed <= 1'b1;
                commit_ptr <= commit_ptr + 1'b1;
            end
            if (drain) begin
                entries[head].busy <= 1'b0;
                head <= head + 1'b1;
            end
            case ({alloc, drain})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_commit_resolved: assert property (@(posedge clock) disable iff (reset)
        commit |-> entries[commit_ptr].busy && entries[commit_ptr].resolved);

    a_alloc_not_full: assert property (@(posedge clock) disable iff (reset)
        alloc |-> !full);

endmodule

// ==== tests/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_tb;
    localparam int MAX_OPS = 160;
    localparam int RANDOM_OPS = 120;
    localparam int CYCLE_LIMIT = 40 * (RANDOM_OPS + 16);

    logic clock = 1'b0;
    logic reset = 1'b1;
    logic load_alloc = 1'b0;
    logic load_resolve_valid = 1'b0;
    logic [`LB_IDX_WIDTH-1:0] load_resolve_idx = '0;
    logic [`ADDR_WIDTH-1:0] load_resolve_addr = '0;
    logic [`TAG_WIDTH-1:0] load_resolve_tag = '0;
    logic store_alloc = 1'b0;
    logic store_resolve_valid = 1'b0;
    logic [`SQ_IDX_WIDTH-1:0] store_resolve_idx = '0;
    logic [`ADDR_WIDTH-1:0] store_resolve_addr = '0;
    logic [`DATA_WIDTH-1:0] store_resolve_data = '0;
    logic store_commit = 1'b0;
    logic [`LB_IDX_WIDTH-1:0] load_alloc_idx;
    logic load_full;
    logic [`SQ_IDX_WIDTH-1:0] store_alloc_idx;
    logic store_full;
    logic load_done_valid;
    logic [`TAG_WIDTH-1:0] load_done_tag;
    logic [`DATA_WIDTH-1:0] load_done_data;

    logic [31:0] lfsr = 32'h3609;
    int cycle_count = 0;
    int mismatches = 0;
    int failures = 0;
    string test_name = "reset";

    // Every operation in program order
    logic                    op_store    [MAX_OPS];
    logic [`ADDR_WIDTH-1:0]  op_addr     [MAX_OPS];
    logic [`DATA_WIDTH-1:0]  op_data     [MAX_OPS];
    logic [`TAG_WIDTH-1:0]   op_tag      [MAX_OPS];
    int                      op_slot     [MAX_OPS];
    logic                    op_resolved [MAX_OPS];
    logic                    op_done     [MAX_OPS];
    logic [`DATA_WIDTH-1:0]  image       [2**`ADDR_WIDTH];
    logic                    lb_busy     [`LB_DEPTH];
    int num_ops = 0;
    int next_alloc = 0;
    int oldest_open = 0;
    int commit_scan = 0;
    int stores_allocated = 0;
    int stores_committed = 0;
    int load_count = 0;
    logic resolve_on = 1'b1;
    logic commit_on = 1'b1;

    lsu_top dut (.*);

    always #50 clock = ~clock;

    always @(posedge clock) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic int lowest_free_load();
        int slot;
        slot = -1;
        for (int i = `LB_DEPTH - 1; i >= 0; i--) begin
            if (!lb_busy[i]) slot = i;
        end
        return slot;
    endfunction

    task automatic check_load(input string name, input logic [`TAG_WIDTH-1:0] exp_tag,
                              input logic [`DATA_WIDTH-1:0] exp_data,
                              input logic [`TAG_WIDTH-1:0] act_tag,
                              input logic [`DATA_WIDTH-1:0] act_data);
        if (act_tag !== exp_tag || act_data !== exp_data) begin
            $display("Mismatch %s: expected tag %0d data %h, actual tag %0d data %h",
                     name, exp_tag, exp_data, act_tag, act_data);
            mismatches++;
        end
    endtask

    task automatic check_index(input string name, input logic [`LB_IDX_WIDTH-1:0] expected,
                               input logic [`LB_IDX_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s %s: expected %0d, actual %0d",
                     test_name, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s %s: expected %b, actual %b", test_name, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic add_op(input logic is_store, input logic [`ADDR_WIDTH-1:0] addr,
                          input logic [`DATA_WIDTH-1:0] data);
        op_store[num_ops] = is_store;
        op_addr[num_ops] = addr;
        op_resolved[num_ops] = 1'b0;
        op_done[num_ops] = 1'b0;
        if (is_store) begin
            image[addr] = data;
            op_data[num_ops] = data;
        end else begin
            // Latest older store to this word, else the initial word
            op_data[num_ops] = image[addr];
            op_tag[num_ops] = `TAG_WIDTH'(load_count);
            load_count++;
        end
        num_ops++;
    endtask

    task automatic complete_load();
        int idx;
        idx = -1;
        for (int i = oldest_open; i < next_alloc; i++) begin
            if (!op_store[i] && op_resolved[i] && !op_done[i] && op_tag[i] == load_done_tag)
                idx = i;
        end
        if (idx < 0) begin
            $display("%s: a load completed with tag %0d but no such load was waiting",
                     test_name, load_done_tag);
            failures++;
        end else begin
            check_load(test_name, op_tag[idx], op_data[idx], load_done_tag, load_done_data);
            // Older stores must be resolved, and aliasing ones committed
            for (int j = oldest_open; j < idx; j++) begin
                if (op_store[j] && (!op_resolved[j] ||
                    (op_addr[j] == op_addr[idx] && !op_done[j]))) begin
                    $display("%s: load %0d completed ahead of older store %0d",
                             test_name, idx, j);
                    failures++;
                end
            end
            op_done[idx] = 1'b1;
            lb_busy[op_slot[idx]] = 1'b0;
        end
    endtask

    task automatic run_cycle();
        int la;
        int sa;
        int lr;
        int sr;
        int cm;
        int cand [$];
        la = -1;
        sa = -1;
        lr = -1;
        sr = -1;
        cm = -1;
        if (next_alloc < num_ops && take_bits(2) != 0) begin
            // store_full does not yet count a store allocated last cycle
            if (op_store[next_alloc] && !store_full && !store_alloc) sa = next_alloc;
            // A store and the load right after it may share a cycle
            if (sa >= 0) la = sa + 1;
            else la = next_alloc;
            if (la >= num_ops || op_store[la] || lowest_free_load() < 0) la = -1;
        end
        for (int i = oldest_open; i < next_alloc; i++) begin
            if (!op_store[i] && !op_resolved[i]) cand.push_back(i);
        end
        if (resolve_on && cand.size() > 0 && take_bits(1) == 1)
            lr = cand[take_bits(8) % cand.size()];
        cand.delete();
        for (int i = oldest_open; i < next_alloc; i++) begin
            if (op_store[i] && !op_resolved[i]) cand.push_back(i);
        end
        if (resolve_on && cand.size() > 0 && take_bits(1) == 1)
            sr = cand[take_bits(8) % cand.size()];
        while (commit_scan < num_ops && (!op_store[commit_scan] || op_done[commit_scan]))
            commit_scan++;
        // Stores retire only behind completed older loads
        if (commit_on && commit_scan < next_alloc && op_resolved[commit_scan]) begin
            cm = commit_scan;
            for (int i = oldest_open; i < commit_scan; i++) begin
                if (!op_store[i] && !op_done[i]) cm = -1;
            end
        end

        @(posedge clock);
        load_alloc <= (la >= 0);
        store_alloc <= (sa >= 0);
        load_resolve_valid <= (lr >= 0);
        store_resolve_valid <= (sr >= 0);
        store_commit <= (cm >= 0);
        if (lr >= 0) begin
            load_resolve_idx <= `LB_IDX_WIDTH'(op_slot[lr]);
            load_resolve_addr <= op_addr[lr];
            load_resolve_tag <= op_tag[lr];
        end
        if (sr >= 0) begin
            store_resolve_idx <= `SQ_IDX_WIDTH'(op_slot[sr]);
            store_resolve_addr <= op_addr[sr];
            store_resolve_data <= op_data[sr];
        end

        @(negedge clock);
        check_flag("load_full", lowest_free_load() < 0, load_full);
        if (stores_allocated - stores_committed == `SQ_DEPTH)
            check_flag("store_full", 1'b1, store_full);
        if (sa >= 0) begin
            op_slot[sa] = stores_allocated % `SQ_DEPTH;
            check_index("store_alloc_idx", `SQ_IDX_WIDTH'(op_slot[sa]), store_alloc_idx);
            stores_allocated++;
            next_alloc = sa + 1;
        end
        if (la >= 0) begin
            op_slot[la] = lowest_free_load();
            check_index("load_alloc_idx", `LB_IDX_WIDTH'(op_slot[la]), load_alloc_idx);
            lb_busy[op_slot[la]] = 1'b1;
            next_alloc = la + 1;
        end
        if (load_done_valid) complete_load();
        if (lr >= 0) op_resolved[lr] = 1'b1;
        if (sr >= 0) op_resolved[sr] = 1'b1;
        if (cm >= 0) begin
            op_done[cm] = 1'b1;
            stores_committed++;
        end
        while (oldest_open < num_ops && op_done[oldest_open]) oldest_open++;
    endtask

    task automatic run_until(input logic loads_only);
        logic open;
        open = 1'b1;
        while (open) begin
            run_cycle();
            open = 1'b0;
            for (int i = oldest_open; i < num_ops; i++) begin
                if (!op_done[i] && !(loads_only && op_store[i])) open = 1'b1;
            end
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("timeout: loads did not complete");
        failures++;
        finish_run();
    end

    initial begin
        for (int a = 0; a < 2**`ADDR_WIDTH; a++) image[a] = `DATA_WIDTH'(a);
        for (int i = 0; i < `LB_DEPTH; i++) lb_busy[i] = 1'b0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_flag("load_full", 1'b0, load_full);
        check_flag("store_full", 1'b0, store_full);
        check_flag("load_done_valid", 1'b0, load_done_valid);

        test_name = "untouched";
        for (int i = 0; i < 4; i++) add_op(1'b0, `ADDR_WIDTH'(48 + i), '0);
        run_until(1'b0);

        // Load must sit behind the aliasing store until it drains
        test_name = "alias";
        commit_on = 1'b0;
        add_op(1'b1, `ADDR_WIDTH'(30), 16'hbeef);
        add_op(1'b0, `ADDR_WIDTH'(30), '0);
        repeat (12) run_cycle();
        commit_on = 1'b1;
        run_until(1'b0);

        test_name = "no alias";
        commit_on = 1'b0;
        add_op(1'b1, `ADDR_WIDTH'(33), 16'h1234);
        add_op(1'b0, `ADDR_WIDTH'(34), '0);
        run_until(1'b1);
        commit_on = 1'b1;
        run_until(1'b0);

        test_name = "fill";
        resolve_on = 1'b0;
        commit_on = 1'b0;
        for (int i = 0; i < 4; i++) add_op(1'b1, `ADDR_WIDTH'(20 + i), `DATA_WIDTH'(take_bits(16)));
        for (int i = 0; i < 4; i++) add_op(1'b0, `ADDR_WIDTH'(20 + i), '0);
        while (next_alloc < num_ops) run_cycle();
        run_cycle();
        check_flag("load_full when filled", 1'b1, load_full);
        check_flag("store_full when filled", 1'b1, store_full);
        resolve_on = 1'b1;
        commit_on = 1'b1;
        run_until(1'b0);
        while (store_full) run_cycle();

        // Small address set so that aliasing is frequent
        test_name = "random";
        for (int i = 0; i < RANDOM_OPS; i++)
            add_op(take_bits(1) == 1, `ADDR_WIDTH'(8 + take_bits(3)), `DATA_WIDTH'(take_bits(16)));
        run_until(1'b0);
        finish_run();
    end

endmodule
